/* filelist.f */
+incdir+logic
logic/sdi_loop_pkg.sv
logic/tx_std_ctrl.sv
logic/rx_loopback_chan.sv
logic/clk_ref_select.sv
logic/hsmc_sdi_loop_top.sv
sim/tb_hsmc_sdi_loop.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sdi loopback testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_hsmc_sdi_loop -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0

/* sim/tb_hsmc_sdi_loop.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sdi_loop_defines.svh"

module tb_hsmc_sdi_loop;

	localparam int NRX = `SDI_NUM_RX;

	logic						tx_p0_pclk_i, reset_i;
	sdi_loop_pkg::sdi_std_t		tx_std_i, tx_p0_std_o;
	sdi_loop_pkg::sdi_word_t	gen_data_i, tx_p0_data_o;
	logic						gen_trs_i, tx_p0_trs_o;
	sdi_loop_pkg::line_num_t	gen_ln_i, tx_p0_ln_o;
	sdi_loop_pkg::sdi_word_t	rx_data_i [NRX], lb_data_o [NRX];
	logic						rx_valid_i [NRX], rx_trs_lock_i [NRX], lb_ready_i [NRX];
	sdi_loop_pkg::sdi_std_t		rx_std_i [NRX], lb_std_o [NRX];
	logic						lb_valid_o [NRX], lb_overflow_o [NRX];
	logic						pattern_rst_o, led_pat_r_o, led_pat_g_o;
	logic						led_lb_r_o [NRX], led_lb_g_o [NRX];
	logic						led_rx_r_o [NRX], led_rx_g_o [NRX];
	logic						fb_use_rx_o, fb_half_o;
	logic [$clog2(NRX)-1:0]		fb_port_o;
	sdi_loop_pkg::vcxo_div_t	vcxo_div_o;
	sdi_loop_pkg::sdi_word_t	exp_q [$];		// loopback words still owed

	hsmc_sdi_loop_top DUT (.*);

	always #5 tx_p0_pclk_i = ~tx_p0_pclk_i;	// 100 MHz pclk

	////////////////////////////////////////////////////////////////////////////
	// failure and compare helpers
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_word(input string n, input sdi_loop_pkg::sdi_word_t act, exp);
		if (act !== exp) abort_run($sformatf("Error %s expected %h actual %h", n, exp, act));
	endtask

	task automatic check_ln(input string n, input sdi_loop_pkg::line_num_t act, exp);
		if (act !== exp) abort_run($sformatf("Error %s expected %h actual %h", n, exp, act));
	endtask

	task automatic check_std(input string n, input sdi_loop_pkg::sdi_std_t act, exp);
		if (act !== exp) abort_run($sformatf("Error %s expected %h actual %h", n, exp, act));
	endtask

	task automatic check_div(input string n, input sdi_loop_pkg::vcxo_div_t act, exp);
		if (act !== exp) abort_run($sformatf("Error %s expected %h actual %h", n, exp, act));
	endtask

	task automatic check_bit(input string n, input logic act, exp);
		if (act !== exp) abort_run($sformatf("Error %s expected %h actual %h", n, exp, act));
	endtask

	// red lights for sd and hd while green lights for all but sd
	task automatic check_leds(input string n, input logic r, g, input sdi_loop_pkg::sdi_std_t s);
		check_bit({n, "_r"}, r, ~s[1]);
		check_bit({n, "_g"}, g, |s);
	endtask

	task automatic next_cycle();
		@(negedge tx_p0_pclk_i);
	endtask

	task automatic wait_valid(input int p, input int max_cyc);
		int cyc;
		cyc = 0;
		while (!lb_valid_o[p]) begin
			next_cycle();
			cyc++;
			if (cyc > max_cyc) abort_run($sformatf("lb_valid_o[%0d] never rose", p));
		end
	endtask

	// pattern reset must drop 9..11 cycles after release or a change
	task automatic wait_pattern_rst_fall(input int start_cyc);
		int cyc;
		cyc = start_cyc;
		while (pattern_rst_o) begin
			next_cycle();
			cyc++;
			if (cyc > start_cyc + 20) abort_run("pattern_rst_o stuck high");
		end
		if (cyc < 9 || cyc > 11)
			abort_run($sformatf("pattern_rst_o fell after %0d cycles, not 9 to 11", cyc));
	endtask

	task automatic push_word(input int p, input logic keep);
		sdi_loop_pkg::sdi_word_t d;
		d = sdi_loop_pkg::sdi_word_t'($urandom);
		rx_valid_i[p] = 1'b1;
		rx_data_i[p] = d;
		if (keep) exp_q.push_back(d);
		next_cycle();
		rx_valid_i[p] = 1'b0;
	endtask

	// drain under random ready with order checked and data held across stalls
	task automatic drain_check(input int p, input int n);
		int got, waited;
		logic stalled, rdy;
		sdi_loop_pkg::sdi_word_t held;
		got = 0;
		waited = 0;
		stalled = 1'b0;
		while (got < n) begin
			if (stalled) begin
				check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b1);
				check_word($sformatf("lb_data_o[%0d]", p), lb_data_o[p], held);
			end
			rdy = 1'($urandom);
			lb_ready_i[p] = rdy;
			stalled = lb_valid_o[p] & ~rdy;
			if (lb_valid_o[p]) begin
				held = exp_q[0];		// oldest word still owed
				check_word($sformatf("lb_data_o[%0d]", p), lb_data_o[p], held);
				if (rdy) begin
					void'(exp_q.pop_front());
					got++;
				end
			end
			next_cycle();
			waited++;
			if (waited > 20 * n + 20) abort_run("loopback drain timed out");
		end
		lb_ready_i[p] = 1'b0;
		next_cycle();
		check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b0);	// drained
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic test_reset_state();
		check_bit("pattern_rst_o", pattern_rst_o, 1'b1);
		for (int k = 0; k < NRX; k++) begin
			check_bit($sformatf("lb_valid_o[%0d]", k), lb_valid_o[k], 1'b0);
			check_bit($sformatf("lb_overflow_o[%0d]", k), lb_overflow_o[k], 1'b0);
			check_leds($sformatf("led_rx[%0d]", k), led_rx_r_o[k], led_rx_g_o[k], `SDI_STD_SD);
			check_leds($sformatf("led_lb[%0d]", k), led_lb_r_o[k], led_lb_g_o[k], `SDI_STD_SD);
		end
		check_leds("led_pat", led_pat_r_o, led_pat_g_o, `SDI_STD_SD);
		check_bit("fb_use_rx_o", fb_use_rx_o, 1'b0);
		check_div("vcxo_div_o", vcxo_div_o, `VCXO_DIV_XO);
		wait_pattern_rst_fall(0);
	endtask

	task automatic change_std(input sdi_loop_pkg::sdi_std_t new_std);
		sdi_loop_pkg::sdi_std_t old_std;
		old_std = tx_std_i;
		tx_std_i = new_std;
		repeat (3) next_cycle();
		check_std("tx_p0_std_o", tx_p0_std_o, old_std);		// sync chain still busy
		next_cycle();
		check_std("tx_p0_std_o", tx_p0_std_o, new_std);
		check_bit("pattern_rst_o", pattern_rst_o, 1'b1);
		check_leds("led_pat", led_pat_r_o, led_pat_g_o, new_std);
		wait_pattern_rst_fall(4);
	endtask

	task automatic test_pattern_latency();
		sdi_loop_pkg::sdi_word_t d;
		logic t;
		sdi_loop_pkg::line_num_t l;
		for (int i = 0; i < 24; i++) begin
			d = sdi_loop_pkg::sdi_word_t'($urandom);
			t = 1'($urandom);
			l = sdi_loop_pkg::line_num_t'($urandom);
			gen_data_i = d;
			gen_trs_i = t;
			gen_ln_i = l;
			next_cycle();
			check_word("tx_p0_data_o", tx_p0_data_o, d);
			check_bit("tx_p0_trs_o", tx_p0_trs_o, t);
			check_ln("tx_p0_ln_o", tx_p0_ln_o, l);
		end
	endtask

	task automatic test_fill_order(input int p);
		exp_q.delete();
		rx_trs_lock_i[p] = 1'b1;
		for (int i = 0; i < 12; i++) begin
			if (i <= 8) check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b0);
			push_word(p, 1'b1);
		end
		wait_valid(p, 4);
		drain_check(p, 12);
	endtask

	task automatic test_flush(input int p);
		exp_q.delete();
		for (int i = 0; i < 5; i++) push_word(p, 1'b0);	// channel is streaming
		check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b1);
		rx_trs_lock_i[p] = 1'b0;
		for (int i = 0; i < 4; i++) begin
			push_word(p, 1'b0);							// dropped while unlocked
			check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b0);
		end
		rx_trs_lock_i[p] = 1'b1;
		for (int i = 0; i < 8; i++) begin
			check_bit($sformatf("lb_valid_o[%0d]", p), lb_valid_o[p], 1'b0);
			push_word(p, 1'b1);
		end
		wait_valid(p, 3);
		drain_check(p, 8);
	endtask

	task automatic test_overflow(input int p);
		exp_q.delete();
		for (int i = 0; i < 20; i++) begin
			if (i == 16) check_bit($sformatf("lb_overflow_o[%0d]", p), lb_overflow_o[p], 1'b0);
			push_word(p, i < 16);
		end
		check_bit($sformatf("lb_overflow_o[%0d]", p), lb_overflow_o[p], 1'b1);
		drain_check(p, 16);
		check_bit($sformatf("lb_overflow_o[%0d]", p), lb_overflow_o[p], 1'b1);	// sticky
		rx_trs_lock_i[p] = 1'b0;
		next_cycle();
		check_bit($sformatf("lb_overflow_o[%0d]", p), lb_overflow_o[p], 1'b0);
	endtask

	// every lock pair against every standard pair including 2'b10
	task automatic test_clk_ref();
		logic [1:0] lk;
		sdi_loop_pkg::sdi_std_t s [NRX];
		logic exp_half;
		for (int c = 0; c < 64; c++) begin
			lk = 2'(c);
			s[0] = sdi_loop_pkg::sdi_std_t'(c >> 2);
			s[1] = sdi_loop_pkg::sdi_std_t'(c >> 4);
			for (int k = 0; k < NRX; k++) begin
				rx_trs_lock_i[k] = lk[k];
				rx_std_i[k] = s[k];
			end
			repeat (2) next_cycle();
			exp_half = lk[1] ? (s[1] != `SDI_STD_HD) : (lk[0] && s[0] != `SDI_STD_HD);
			check_bit("fb_use_rx_o", fb_use_rx_o, |lk);
			check_bit("fb_port_o", fb_port_o, lk[1]);		// port 1 outranks port 0
			check_bit("fb_half_o", fb_half_o, exp_half);
			check_div("vcxo_div_o", vcxo_div_o, (|lk) ? `VCXO_DIV_RX : `VCXO_DIV_XO);
			for (int k = 0; k < NRX; k++) begin
				check_std($sformatf("lb_std_o[%0d]", k), lb_std_o[k], s[k]);
				check_leds($sformatf("led_rx[%0d]", k), led_rx_r_o[k], led_rx_g_o[k], s[k]);
				check_leds($sformatf("led_lb[%0d]", k), led_lb_r_o[k], led_lb_g_o[k], s[k]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'h15a3_4f91));
		tx_p0_pclk_i = 1'b0;
		reset_i = 1'b1;
		tx_std_i = `SDI_STD_SD;
		gen_data_i = '0;
		gen_trs_i = 1'b0;
		gen_ln_i = '0;
		for (int k = 0; k < NRX; k++) begin
			rx_data_i[k] = '0;
			rx_valid_i[k] = 1'b0;
			rx_trs_lock_i[k] = 1'b0;	// unlocked channels sit flushed
			rx_std_i[k] = `SDI_STD_SD;
			lb_ready_i[k] = 1'b0;
		end
		repeat (8) next_cycle();
		reset_i = 1'b0;
		test_reset_state();
		change_std(`SDI_STD_HD);
		change_std(`SDI_STD_3G);
		test_pattern_latency();
		for (int p = 0; p < NRX; p++) begin
			test_fill_order(p);
			test_flush(p);
			test_overflow(p);
		end
		test_clk_ref();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/hsmc_sdi_loop_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sdi_loop_defines.svh"

module hsmc_sdi_loop_top (
	input  wire							tx_p0_pclk_i,
	input  wire							reset_i,
	// pattern transmit path
	input  wire sdi_loop_pkg::sdi_std_t	tx_std_i,
	input  wire sdi_loop_pkg::sdi_word_t	gen_data_i,
	input  wire							gen_trs_i,
	input  wire sdi_loop_pkg::line_num_t	gen_ln_i,
	// receivers, one entry per port
	input  wire sdi_loop_pkg::sdi_word_t	rx_data_i [`SDI_NUM_RX],
	input  wire							rx_valid_i [`SDI_NUM_RX],
	input  wire							rx_trs_lock_i [`SDI_NUM_RX],
	input  wire sdi_loop_pkg::sdi_std_t	rx_std_i [`SDI_NUM_RX],
	input  wire							lb_ready_i [`SDI_NUM_RX],
	output logic						pattern_rst_o,
	output sdi_loop_pkg::sdi_word_t		tx_p0_data_o,
	output logic						tx_p0_trs_o,
	output sdi_loop_pkg::line_num_t		tx_p0_ln_o,
	output sdi_loop_pkg::sdi_std_t		tx_p0_std_o,
	// loopback transmitters
	output sdi_loop_pkg::sdi_word_t		lb_data_o [`SDI_NUM_RX],
	output logic						lb_valid_o [`SDI_NUM_RX],
	output sdi_loop_pkg::sdi_std_t		lb_std_o [`SDI_NUM_RX],
	output logic						lb_overflow_o [`SDI_NUM_RX],
	// board leds
	output logic						led_pat_r_o,
	output logic						led_pat_g_o,
	output logic						led_lb_r_o [`SDI_NUM_RX],
	output logic						led_lb_g_o [`SDI_NUM_RX],
	output logic						led_rx_r_o [`SDI_NUM_RX],
	output logic						led_rx_g_o [`SDI_NUM_RX],
	// daughter card clock generator
	output logic						fb_use_rx_o,
	output logic [$clog2(`SDI_NUM_RX)-1:0]	fb_port_o,
	output logic						fb_half_o,
	output sdi_loop_pkg::vcxo_div_t		vcxo_div_o
);

	logic						chan_lock [`SDI_NUM_RX];	// to clock ref pick
	sdi_loop_pkg::sdi_std_t		chan_std [`SDI_NUM_RX];

	///////////////////////////////////////////////////////////////////////////
	// pattern transmitter, port 0
	tx_std_ctrl u_tx_std_ctrl (
		.tx_p0_pclk_i	(tx_p0_pclk_i),
		.reset_i		(reset_i),
		.tx_std_i		(tx_std_i),
		.gen_data_i		(gen_data_i),
		.gen_trs_i		(gen_trs_i),
		.gen_ln_i		(gen_ln_i),
		.pattern_rst_o	(pattern_rst_o),
		.tx_p0_data_o	(tx_p0_data_o),
		.tx_p0_trs_o	(tx_p0_trs_o),
		.tx_p0_ln_o		(tx_p0_ln_o),
		.tx_p0_std_o	(tx_p0_std_o),
		.led_pat_r_o	(led_pat_r_o),
		.led_pat_g_o	(led_pat_g_o)
	);

	///////////////////////////////////////////////////////////////////////////
	// loopback, every receive port
	for (genvar k = 0; k < `SDI_NUM_RX; k++) begin : g_chan
		rx_loopback_chan u_chan (
			.tx_p0_pclk_i	(tx_p0_pclk_i),
			.reset_i		(reset_i),
			.rx_data_i		(rx_data_i[k]),
			.rx_valid_i		(rx_valid_i[k]),
			.rx_trs_lock_i	(rx_trs_lock_i[k]),
			.rx_std_i		(rx_std_i[k]),
			.lb_ready_i		(lb_ready_i[k]),
			.lb_data_o		(lb_data_o[k]),
			.lb_valid_o		(lb_valid_o[k]),
			.lb_std_o		(lb_std_o[k]),
			.lb_overflow_o	(lb_overflow_o[k]),
			.chan_lock_o	(chan_lock[k]),
			.chan_std_o		(chan_std[k]),
			.led_rx_r_o		(led_rx_r_o[k]),
			.led_rx_g_o		(led_rx_g_o[k]),
			.led_lb_r_o		(led_lb_r_o[k]),
			.led_lb_g_o		(led_lb_g_o[k])
		);
	end

	// feedback source and divider for the vcxo pll
	clk_ref_select u_clk_ref_select (
		.tx_p0_pclk_i	(tx_p0_pclk_i),
		.reset_i		(reset_i),
		.chan_lock_i	(chan_lock),
		.chan_std_i		(chan_std),
		.fb_use_rx_o	(fb_use_rx_o),
		.fb_port_o		(fb_port_o),
		.fb_half_o		(fb_half_o),
		.vcxo_div_o		(vcxo_div_o)
	);

endmodule

`default_nettype wire

/* logic/clk_ref_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sdi_loop_defines.svh"

module clk_ref_select (
	input  wire							tx_p0_pclk_i,
	input  wire							reset_i,
	input  wire							chan_lock_i [`SDI_NUM_RX],
	input  wire sdi_loop_pkg::sdi_std_t	chan_std_i [`SDI_NUM_RX],
	output logic						fb_use_rx_o,	// 0 = crystal ref
	output logic [$clog2(`SDI_NUM_RX)-1:0]	fb_port_o,
	output logic						fb_half_o,		// recovered clock / 2
	output sdi_loop_pkg::vcxo_div_t		vcxo_div_o
);

	localparam int PORT_W = $clog2(`SDI_NUM_RX);

	logic					sel_found;
	logic [PORT_W-1:0]		sel_port;
	sdi_loop_pkg::sdi_std_t	sel_std;

	///////////////////////////////////////////////////////////////////////////
	// priority pick, later ports override earlier ones
	always_comb begin
		sel_found	= 1'b0;
		sel_port	= '0;
		sel_std		= `SDI_STD_SD;
		for (int k = 0; k < `SDI_NUM_RX; k++) begin
			if (chan_lock_i[k]) begin
				sel_found	= 1'b1;
				sel_port	= PORT_W'(k);
				sel_std		= chan_std_i[k];
			end
		end
	end

	// registered pins to the vcxo pll and feedback mux
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			fb_use_rx_o	<= 1'b0;
			fb_port_o	<= '0;
			fb_half_o	<= 1'b0;
			vcxo_div_o	<= `VCXO_DIV_XO;	// no receiver at power up
		end else begin
			fb_use_rx_o	<= sel_found;
			fb_port_o	<= sel_port;
			// hd runs 74.25 MHz straight, sd and 3g are halved
			fb_half_o	<= sel_found && (sel_std != `SDI_STD_HD);
			vcxo_div_o	<= sel_found ? `VCXO_DIV_RX : `VCXO_DIV_XO;
		end
	end

	a_div_legal: assert property (@(posedge tx_p0_pclk_i) disable iff (reset_i)
		(vcxo_div_o == `VCXO_DIV_XO) || (vcxo_div_o == `VCXO_DIV_RX));

endmodule

`default_nettype wire

/* logic/rx_loopback_chan.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sdi_loop_defines.svh"

module rx_loopback_chan (
	input  wire							tx_p0_pclk_i,
	input  wire							reset_i,
	input  wire sdi_loop_pkg::sdi_word_t	rx_data_i,
	input  wire							rx_valid_i,
	input  wire							rx_trs_lock_i,	// low = flush
	input  wire sdi_loop_pkg::sdi_std_t	rx_std_i,
	input  wire							lb_ready_i,
	output sdi_loop_pkg::sdi_word_t		lb_data_o,
	output logic						lb_valid_o,
	output sdi_loop_pkg::sdi_std_t		lb_std_o,		// loopback tx standard
	output logic						lb_overflow_o,	// sticky
	output logic						chan_lock_o,
	output sdi_loop_pkg::sdi_std_t		chan_std_o,
	output logic						led_rx_r_o,
	output logic						led_rx_g_o,
	output logic						led_lb_r_o,
	output logic						led_lb_g_o
);

	localparam int PTR_W = $clog2(`LB_FIFO_DEPTH);

	sdi_loop_pkg::sdi_word_t	mem [`LB_FIFO_DEPTH];	// loopback storage
	logic [PTR_W-1:0]			wr_ptr, rd_ptr;
	sdi_loop_pkg::fill_cnt_t	fill_cnt;
	sdi_loop_pkg::lb_state_e	lb_state;
	logic						fifo_full, flush;
	logic						wr_en, rd_en;

	assign fifo_full	= (fill_cnt == sdi_loop_pkg::fill_cnt_t'(`LB_FIFO_DEPTH));
	assign flush		= ~rx_trs_lock_i;			// lost trs lock empties the queue
	assign wr_en		= rx_valid_i & rx_trs_lock_i & ~fifo_full;
	assign rd_en		= lb_valid_o & lb_ready_i;	// word leaves on handshake

	///////////////////////////////////////////////////////////////////////////
	// storage, write side only
	always_ff @(posedge tx_p0_pclk_i) begin
		if (wr_en)
			mem[wr_ptr] <= rx_data_i;
	end

	// pointers and fill count
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			wr_ptr		<= '0;
			rd_ptr		<= '0;
			fill_cnt	<= '0;
		end else if (flush) begin
			wr_ptr		<= '0;
			rd_ptr		<= '0;
			fill_cnt	<= '0;
		end else begin
			if (wr_en)
				wr_ptr	<= wr_ptr + 1'b1;	// wraps, depth is 2^n
			if (rd_en)
				rd_ptr	<= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:		fill_cnt <= fill_cnt + 1'b1;
				2'b01:		fill_cnt <= fill_cnt - 1'b1;
				default:	fill_cnt <= fill_cnt;	// both or neither
			endcase
		end
	end

	///////////////////////////////////////////////////////////////////////////
	// fill / stream fsm and overflow flag
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			lb_state		<= sdi_loop_pkg::LB_FILL;
			lb_overflow_o	<= 1'b0;
		end else if (flush) begin
			lb_state		<= sdi_loop_pkg::LB_FILL;
			lb_overflow_o	<= 1'b0;
		end else begin
			if (lb_state == sdi_loop_pkg::LB_FILL &&
				fill_cnt >= sdi_loop_pkg::fill_cnt_t'(`LB_FIFO_DEPTH / 2))
				lb_state	<= sdi_loop_pkg::LB_STREAM;	// half full, start playout
			if (rx_valid_i && fifo_full)
				lb_overflow_o	<= 1'b1;	// word dropped
		end
	end

	// first word fall through, valid never looks at ready
	assign lb_valid_o	= (lb_state == sdi_loop_pkg::LB_STREAM) && (fill_cnt != '0);
	assign lb_data_o	= mem[rd_ptr];

	// lock and standard, one register
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			chan_lock_o	<= 1'b0;
			chan_std_o	<= `SDI_STD_SD;
		end else begin
			chan_lock_o	<= rx_trs_lock_i;
			chan_std_o	<= rx_std_i;
		end
	end

	assign lb_std_o		= chan_std_o;	// loop back at the received rate
	assign led_rx_r_o	= sdi_loop_pkg::std_led_red(chan_std_o);
	assign led_rx_g_o	= sdi_loop_pkg::std_led_green(chan_std_o);
	assign led_lb_r_o	= sdi_loop_pkg::std_led_red(lb_std_o);
	assign led_lb_g_o	= sdi_loop_pkg::std_led_green(lb_std_o);

	///////////////////////////////////////////////////////////////////////////
	a_valid_not_empty: assert property (@(posedge tx_p0_pclk_i) disable iff (reset_i)
		lb_valid_o |-> (fill_cnt != '0));

	// stalled word holds until taken, unless the channel is flushed
	a_stall_stable: assert property (@(posedge tx_p0_pclk_i) disable iff (reset_i)
		(lb_valid_o && !lb_ready_i && rx_trs_lock_i) |=> (lb_valid_o && $stable(lb_data_o)));

	a_fill_bound: assert property (@(posedge tx_p0_pclk_i) disable iff (reset_i)
		fill_cnt <= sdi_loop_pkg::fill_cnt_t'(`LB_FIFO_DEPTH));

endmodule

`default_nettype wire

/* logic/tx_std_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sdi_loop_defines.svh"

module tx_std_ctrl (
	input  wire							tx_p0_pclk_i,
	input  wire							reset_i,
	input  wire sdi_loop_pkg::sdi_std_t	tx_std_i,		// requested standard, async
	input  wire sdi_loop_pkg::sdi_word_t	gen_data_i,
	input  wire							gen_trs_i,
	input  wire sdi_loop_pkg::line_num_t	gen_ln_i,
	output logic						pattern_rst_o,	// reset to pattern gen
	output sdi_loop_pkg::sdi_word_t		tx_p0_data_o,
	output logic						tx_p0_trs_o,
	output sdi_loop_pkg::line_num_t		tx_p0_ln_o,
	output sdi_loop_pkg::sdi_std_t		tx_p0_std_o,
	output logic						led_pat_r_o,
	output logic						led_pat_g_o
);

	sdi_loop_pkg::sdi_std_t			std_s1, std_s2, std_s3;	// sync chain
	sdi_loop_pkg::tx_rst_state_e	rst_state;
	logic [`TX_RST_CNT_W-1:0]		rst_cnt;
	logic							std_change;

	///////////////////////////////////////////////////////////////////////////
	// standard request sync, then one more register toward the transmitter
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			std_s1		<= `SDI_STD_SD;
			std_s2		<= `SDI_STD_SD;
			std_s3		<= `SDI_STD_SD;
			tx_p0_std_o	<= `SDI_STD_SD;
		end else begin
			std_s1		<= tx_std_i;
			std_s2		<= std_s1;
			std_s3		<= std_s2;
			tx_p0_std_o	<= std_s3;		// 4 edges after first sample
		end
	end

	assign std_change = (std_s1 != std_s3);	// new value still in flight

	///////////////////////////////////////////////////////////////////////////
	// reset stretch for the pattern generator
	// counter restarts on entry to hold, msb ends the hold
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			rst_state	<= sdi_loop_pkg::TXR_HOLD;
			rst_cnt		<= '0;
		end else begin
			case (rst_state)
				sdi_loop_pkg::TXR_RUN: begin
					if (std_change) begin
						rst_state	<= sdi_loop_pkg::TXR_HOLD;
						rst_cnt		<= '0;
					end
				end
				default: begin
					if (rst_cnt[`TX_RST_CNT_W-1] && !std_change)
						rst_state	<= sdi_loop_pkg::TXR_RUN;
					else if (!rst_cnt[`TX_RST_CNT_W-1])
						rst_cnt		<= rst_cnt + 1'b1;	// saturates at terminal count
				end
			endcase
		end
	end

	assign pattern_rst_o = (rst_state == sdi_loop_pkg::TXR_HOLD);

	// generator output, one register stage to the serialiser
	always_ff @(posedge tx_p0_pclk_i or posedge reset_i) begin
		if (reset_i) begin
			tx_p0_data_o	<= '0;
			tx_p0_trs_o		<= 1'b0;
			tx_p0_ln_o		<= '0;
		end else begin
			tx_p0_data_o	<= gen_data_i;
			tx_p0_trs_o		<= gen_trs_i;
			tx_p0_ln_o		<= gen_ln_i;
		end
	end

	assign led_pat_r_o = sdi_loop_pkg::std_led_red(tx_p0_std_o);
	assign led_pat_g_o = sdi_loop_pkg::std_led_green(tx_p0_std_o);

	// a standard still crossing the sync chain keeps the generator in reset
	a_change_holds_rst: assert property (@(posedge tx_p0_pclk_i) disable iff (reset_i)
		std_change |=> pattern_rst_o);

endmodule

`default_nettype wire

/* logic/sdi_loop_pkg.sv */
`default_nettype none

`include "sdi_loop_defines.svh"

package sdi_loop_pkg;

	typedef logic [`SDI_DATA_W-1:0]		sdi_word_t;	// one parallel word
	typedef logic [`SDI_LN_W-1:0]		line_num_t;
	typedef logic [1:0]					sdi_std_t;	// sd / hd / 3g code
	typedef logic [3:0]					vcxo_div_t;	// vcxo divider pins
	typedef logic [`LB_CNT_W-1:0]		fill_cnt_t;

	// pattern generator reset stretcher
	typedef enum logic {
		TXR_HOLD,	// generator held in reset
		TXR_RUN
	} tx_rst_state_e;

	// loopback read side
	typedef enum logic {
		LB_FILL,	// wait for half full
		LB_STREAM
	} lb_state_e;

	///////////////////////////////////////////////////////////////////////////
	// led code: red = sd, red+green = hd, green = 3g
	function automatic logic std_led_red(input sdi_std_t std);
		return (std == `SDI_STD_SD) || (std == `SDI_STD_HD);
	endfunction

	function automatic logic std_led_green(input sdi_std_t std);
		return (std != `SDI_STD_SD);	// hd, 3g and the 2'b10 alias
	endfunction

endpackage

`default_nettype wire

/* logic/sdi_loop_defines.svh */
`ifndef SDI_LOOP_DEFINES_SVH
`define SDI_LOOP_DEFINES_SVH

///////////////////////////////////////////////////////////////////////////
// datapath widths
`define SDI_DATA_W	20		// parallel sdi word, 20 bit for hd/3g
`define SDI_LN_W	11		// line number
`define SDI_NUM_RX	2		// receive ports, one loopback channel each

///////////////////////////////////////////////////////////////////////////
// loopback buffer
`define LB_FIFO_DEPTH	16		// keep a power of two
`define LB_CNT_W		5		// fill count, 0..depth inclusive
`define TX_RST_CNT_W	4		// msb = terminal count of reset stretch

///////////////////////////////////////////////////////////////////////////
// video standard codes
// 2'b10 is decoded as 3G as well
`define SDI_STD_SD	2'b00	// 270 Mbps
`define SDI_STD_HD	2'b01	// 1.485 Gbps
`define SDI_STD_3G	2'b11	// 2.97 Gbps

// divider select for the daughter card vcxo pll
`define VCXO_DIV_XO	4'b1010		// M/P = 92, crystal ref
`define VCXO_DIV_RX	4'b1001		// M=92 P=253, recovered rx clock

`endif
